// ==== apb_front.sv ====
// zero wait state apb slave; access without a preceding setup gets pready but no cache request
`timescale 1ns/1ns

module apb_front
  import dcache_pkg::*;
#(
  parameter int index_bits = 3
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [addr_width-1:0] paddr,
  input  logic [data_width-1:0] pwdata,
  output logic [data_width-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  hit_any,
  input  logic [data_width-1:0] hit_data,
  cache_req_if.front            req
);

  localparam int tag_bits = addr_width - 2 - index_bits;

  apb_state_t state;
  apb_state_t phase;
  logic       access_ok;

  // bus phase of the current cycle
  always_comb begin
    if (!psel) begin
      phase = st_idle;
    end else if (!penable) begin
      phase = st_setup;
    end else begin
      phase = st_access;
    end
  end

  // remembers the previous phase so access must follow setup
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= phase;
    end
  end

  assign access_ok = (phase == st_access) && (state == st_setup);

  // address split with the offset bits dropped
  assign req.tag   = paddr[addr_width-1 -: tag_bits];
  assign req.index = paddr[2 +: index_bits];
  assign req.wdata = pwdata;
  assign req.op    = pwrite ? op_write : op_read;
  assign req.fire  = access_ok;

  // no wait states
  assign pready = (phase == st_access);

  // read miss answers zero with an error
  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (access_ok && !pwrite) begin
      if (hit_any) begin
        prdata = hit_data;
      end else begin
        pslverr = 1'b1;
      end
    end
  end

endmodule

// ==== cache_req_if.sv ====
// request is only meaningful while fire is high; index_bits must match the ways and selector
`timescale 1ns/1ns

interface cache_req_if
  import dcache_pkg::*;
#(
  parameter int index_bits = 3
) ();

  localparam int tag_bits = addr_width - 2 - index_bits;

  logic [index_bits-1:0] index;
  logic [tag_bits-1:0]   tag;
  logic [data_width-1:0] wdata;
  cache_op_t             op;
  // high for the single apb access cycle
  logic                  fire;

  modport front (output index, output tag, output wdata, output op, output fire);
  modport way (input index, input tag, input wdata, input op, input fire);
  modport select (input index, input tag, input wdata, input op, input fire);

endinterface

// ==== cache_way.sv ====
// one way of the cache; tag and data arrays are not reset, only valid and dirty are
`timescale 1ns/1ns

module cache_way
  import dcache_pkg::*;
#(
  parameter int index_bits = 3
) (
  input  logic        clock,
  input  logic        reset,
  cache_req_if.way    req,
  way_port_if.way     port
);

  localparam int tag_bits = addr_width - 2 - index_bits;
  localparam int num_sets = 1 << index_bits;

  logic [tag_bits-1:0]   tag_mem  [num_sets];
  logic [data_width-1:0] data_mem [num_sets];
  logic [num_sets-1:0]   valid_bits;
  logic [num_sets-1:0]   dirty_bits;

  // combinational lookup on the requested set
  assign port.hit = valid_bits[req.index] && (tag_mem[req.index] == req.tag);
  assign port.rdata = data_mem[req.index];

  // whole indexed line offered as the replacement candidate
  assign port.victim_tag   = tag_mem[req.index];
  assign port.victim_valid = valid_bits[req.index];
  assign port.victim_dirty = dirty_bits[req.index];

  // line payload
  always_ff @(posedge clock) begin
    if (port.wen) begin
      tag_mem[req.index]  <= req.tag;
      data_mem[req.index] <= req.wdata;
    end
  end

  // every write leaves the line dirty as there is no clean fill
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (port.wen) begin
      valid_bits[req.index] <= 1'b1;
      dirty_bits[req.index] <= 1'b1;
    end
  end

endmodule

// ==== dcache_pkg.sv ====
// four ways fixed by the three-bit tree; byte addresses with the low two bits ignored
package dcache_pkg;

  // bits 1:0 of the apb address are the word offset
  localparam int addr_width = 16;

  // one 32-bit word per line as on the apb data bus
  localparam int data_width = 32;

  // tree pseudo-lru below only works for four ways
  localparam int num_ways = 4;

  // apb slave phase
  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } apb_state_t;

  // request kind sent to the ways
  typedef enum logic {
    op_read,
    op_write
  } cache_op_t;

endpackage

// ==== dcache_top.sv ====
// apb data cache, write-allocate with write-back eviction; no refill, read miss returns pslverr
`timescale 1ns/1ns

module dcache_top
  import dcache_pkg::*;
#(
  parameter int index_bits = 3
) (
  input  logic                  clock,
  input  logic                  reset,

  // apb slave
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [addr_width-1:0] paddr,
  input  logic [data_width-1:0] pwdata,
  output logic [data_width-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,

  // write-back stream that must be taken every cycle
  output logic                  evict_valid,
  output logic [addr_width-1:0] evict_addr,
  output logic [data_width-1:0] evict_data
);

  logic                  hit_any;
  logic [data_width-1:0] hit_data;

  cache_req_if #(.index_bits(index_bits)) req_bus ();
  way_port_if  #(.index_bits(index_bits)) way_bus [num_ways] ();

  apb_front #(
    .index_bits (index_bits)
  ) apb_front_i (
    .clock    (clock),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .hit_any  (hit_any),
    .hit_data (hit_data),
    .req      (req_bus.front)
  );

  // four identical ways
  for (genvar w = 0; w < num_ways; w++) begin : g_way
    cache_way #(
      .index_bits (index_bits)
    ) cache_way_i (
      .clock (clock),
      .reset (reset),
      .req   (req_bus.way),
      .port  (way_bus[w].way)
    );
  end

  way_select #(
    .index_bits (index_bits)
  ) way_select_i (
    .clock       (clock),
    .reset       (reset),
    .req         (req_bus.select),
    .ports       (way_bus),
    .hit_any     (hit_any),
    .hit_data    (hit_data),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr),
    .evict_data  (evict_data)
  );

endmodule

// ==== run_dcache.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_dcache -f tb.f -o sim_dcache
output="$(./obj_dir/sim_dcache)"
echo "$output"
if echo "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

// ==== tb.f ====
dcache_pkg.sv
cache_req_if.sv
way_port_if.sv
apb_front.sv
cache_way.sv
way_select.sv
dcache_top.sv
tb_dcache.sv

// ==== tb_dcache.sv ====
// directed dcache_top test at index_bits 3; assumes zero wait states, one idle cycle per transfer
`timescale 1ns/1ns

module tb_dcache
  import dcache_pkg::*;
();

  localparam int index_bits = 3;
  localparam int tag_bits = addr_width - 2 - index_bits;
  localparam int num_sets = 1 << index_bits;
  localparam int max_cycles = 2000;

  logic clock, reset, psel, penable, pwrite;
  logic [addr_width-1:0] paddr, evict_addr, ev_addr;
  logic [data_width-1:0] pwdata, prdata, evict_data, resp_rdata, ev_data;
  logic pready, pslverr, evict_valid, resp_ready, resp_slverr, ev_valid;

  // reference model of the cache contents and tree bits
  logic [tag_bits-1:0]   m_tag   [num_sets][num_ways];
  logic [data_width-1:0] m_data  [num_sets][num_ways];
  logic                  m_valid [num_sets][num_ways];
  logic                  m_a [num_sets];
  logic                  m_b [num_sets];
  logic                  m_c [num_sets];

  int errors;
  int cycle_count;

  dcache_top #(.index_bits(index_bits)) dcache_top_i (
    .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .evict_valid(evict_valid), .evict_addr(evict_addr), .evict_data(evict_data)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // stops a hung run
  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", max_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic logic lookup(input logic [index_bits-1:0] set_idx,
                                  input logic [tag_bits-1:0] tag, output logic [1:0] way);
    logic found;
    found = 1'b0;
    way = 2'd0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
        found = 1'b1;
        way = 2'(w);
      end
    end
    return found;
  endfunction

  // tree walk where a picks the half
  function automatic logic [1:0] victim_of(input logic [index_bits-1:0] set_idx);
    if (!m_a[set_idx]) return m_b[set_idx] ? 2'd1 : 2'd0;
    return m_c[set_idx] ? 2'd3 : 2'd2;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error: %s expected %h got %h", name, exp, got);
    errors++;
  endtask

  // setup, access, then one idle cycle where an eviction would show
  task automatic run_transfer(input logic write, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    // a pulse from an earlier write must be gone by now
    @(negedge clock);
    if (evict_valid !== 1'b0) report_mismatch("evict_valid", 32'(evict_valid), 32'h0);
    @(posedge clock);
    #1 penable = 1'b1;
    @(negedge clock);
    resp_ready = pready;
    resp_rdata = prdata;
    resp_slverr = pslverr;
    @(posedge clock);
    #1 psel = 1'b0;
    penable = 1'b0;
    @(negedge clock);
    ev_valid = evict_valid;
    ev_addr = evict_addr;
    ev_data = evict_data;
    @(posedge clock);
    #1;
  endtask

  task automatic check_eviction(input logic exp_valid, input logic [addr_width-1:0] exp_addr,
                                input logic [data_width-1:0] exp_data);
    if (ev_valid !== exp_valid) report_mismatch("evict_valid", 32'(ev_valid), 32'(exp_valid));
    if (exp_valid && ev_addr !== exp_addr) begin
      report_mismatch("evict_addr", 32'(ev_addr), 32'(exp_addr));
    end
    if (exp_valid && ev_data !== exp_data) report_mismatch("evict_data", ev_data, exp_data);
  endtask

  task automatic apb_write(input logic [addr_width-1:0] addr, input logic [data_width-1:0] data);
    logic [index_bits-1:0] set_idx;
    logic [tag_bits-1:0] tag;
    logic [1:0] way;
    logic exp_evict;
    logic [addr_width-1:0] exp_addr;
    logic [data_width-1:0] exp_data;
    set_idx = addr[2 +: index_bits];
    tag = addr[addr_width-1 -: tag_bits];
    exp_evict = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    if (!lookup(set_idx, tag, way)) begin
      way = victim_of(set_idx);
      exp_evict = m_valid[set_idx][way];
      exp_addr = {m_tag[set_idx][way], set_idx, 2'b00};
      exp_data = m_data[set_idx][way];
      // tree moves on allocation only
      if (!m_a[set_idx]) m_b[set_idx] = ~m_b[set_idx];
      else m_c[set_idx] = ~m_c[set_idx];
      m_a[set_idx] = ~m_a[set_idx];
    end
    run_transfer(1'b1, addr, data);
    if (resp_ready !== 1'b1) begin
      $display("pready was not high in the access cycle of the write to %h", addr);
      errors++;
    end
    if (resp_slverr !== 1'b0) report_mismatch("pslverr", 32'(resp_slverr), 32'h0);
    check_eviction(exp_evict, exp_addr, exp_data);
    m_tag[set_idx][way] = tag;
    m_data[set_idx][way] = data;
    m_valid[set_idx][way] = 1'b1;
  endtask

  task automatic apb_read(input logic [addr_width-1:0] addr);
    logic [1:0] way;
    logic found;
    logic [data_width-1:0] exp_data;
    found = lookup(addr[2 +: index_bits], addr[addr_width-1 -: tag_bits], way);
    exp_data = found ? m_data[addr[2 +: index_bits]][way] : '0;
    run_transfer(1'b0, addr, '0);
    if (resp_ready !== 1'b1) begin
      $display("pready was not high in the access cycle of the read of %h", addr);
      errors++;
    end
    if (resp_rdata !== exp_data) report_mismatch("prdata", resp_rdata, exp_data);
    if (resp_slverr !== !found) report_mismatch("pslverr", 32'(resp_slverr), 32'(!found));
    check_eviction(1'b0, '0, '0);
  endtask

  task automatic reads_after_reset();
    @(negedge clock);
    if (pready !== 1'b0) report_mismatch("pready", 32'(pready), 32'h0);
    if (pslverr !== 1'b0) report_mismatch("pslverr", 32'(pslverr), 32'h0);
    if (evict_valid !== 1'b0) report_mismatch("evict_valid", 32'(evict_valid), 32'h0);
    @(posedge clock);
    #1;
    apb_read(16'h0000);
    apb_read(16'h1234);
    apb_read(16'hfffc);
    apb_read(16'h0a50);
  endtask

  task automatic write_then_read();
    apb_write({11'h0a3, 3'd0, 2'b00}, $urandom);
    apb_read({11'h0a3, 3'd0, 2'b00});
    apb_write({11'h0a3, 3'd0, 2'b00}, $urandom);
    apb_read({11'h0a3, 3'd0, 2'b10});
  endtask

  // fills ways 0, 2, 1, 3 of set 5
  task automatic fill_one_set();
    for (int t = 0; t < num_ways; t++) apb_write({11'(12'h100 + t), 3'd5, 2'b00}, $urandom);
    for (int t = 0; t < num_ways; t++) apb_read({11'(12'h100 + t), 3'd5, 2'b00});
  endtask

  task automatic evict_full_set();
    apb_write({11'h104, 3'd5, 2'b00}, $urandom);
    apb_read({11'h100, 3'd5, 2'b00});
    apb_read({11'h104, 3'd5, 2'b00});
  endtask

  // few tags per set so hits, misses and evictions all occur
  task automatic random_traffic();
    logic [addr_width-1:0] addr;
    repeat (120) begin
      addr = {11'($urandom % 6), 3'($urandom), 2'($urandom)};
      if ($urandom % 5 < 3) apb_write(addr, $urandom);
      else apb_read(addr);
    end
  endtask

  initial begin
    void'($urandom(32'h9d5c));
    errors = 0;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    for (int s = 0; s < num_sets; s++) begin
      m_a[s] = 1'b0;
      m_b[s] = 1'b0;
      m_c[s] = 1'b0;
      for (int w = 0; w < num_ways; w++) m_valid[s][w] = 1'b0;
    end
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
    reads_after_reset();
    write_then_read();
    fill_one_set();
    evict_full_set();
    random_traffic();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== way_port_if.sv ====
// one instance per way; all lookup fields refer to the set of the current request
`timescale 1ns/1ns

interface way_port_if
  import dcache_pkg::*;
#(
  parameter int index_bits = 3
) ();

  localparam int tag_bits = addr_width - 2 - index_bits;

  // lookup result for the requested tag
  logic                  hit;
  // stored word serves as hit data and as victim data
  logic [data_width-1:0] rdata;

  // current contents of the indexed line
  logic [tag_bits-1:0]   victim_tag;
  logic                  victim_valid;
  logic                  victim_dirty;

  // commit request tag and data into the indexed line
  logic                  wen;

  modport way (
    output hit,
    output rdata,
    output victim_tag,
    output victim_valid,
    output victim_dirty,
    input  wen
  );

  modport select (
    input  hit,
    input  rdata,
    input  victim_tag,
    input  victim_valid,
    input  victim_dirty,
    output wen
  );

endinterface

// ==== way_select.sv ====
// fixed four-way tree plru; tree bits move on allocation only, eviction port cannot stall
`timescale 1ns/1ns

module way_select
  import dcache_pkg::*;
#(
  parameter int index_bits = 3
) (
  input  logic                  clock,
  input  logic                  reset,
  cache_req_if.select           req,
  way_port_if.select            ports [num_ways],
  output logic                  hit_any,
  output logic [data_width-1:0] hit_data,
  output logic                  evict_valid,
  output logic [addr_width-1:0] evict_addr,
  output logic [data_width-1:0] evict_data
);

  localparam int tag_bits = addr_width - 2 - index_bits;
  localparam int num_sets = 1 << index_bits;

  // per-way copies of the interface array
  logic [num_ways-1:0]   way_hit;
  logic [data_width-1:0] way_data  [num_ways];
  logic [tag_bits-1:0]   vic_tag   [num_ways];
  logic [num_ways-1:0]   vic_valid;
  logic [num_ways-1:0]   vic_dirty;
  logic [num_ways-1:0]   wen;

  // tree bits where a picks the half and b or c picks within it
  logic [num_sets-1:0]   tree_a;
  logic [num_sets-1:0]   tree_b;
  logic [num_sets-1:0]   tree_c;

  logic [1:0]            hit_way;
  logic [1:0]            victim_way;
  logic                  write_req;
  logic                  alloc;

  for (genvar w = 0; w < num_ways; w++) begin : g_port
    assign way_hit[w]   = ports[w].hit;
    assign way_data[w]  = ports[w].rdata;
    assign vic_tag[w]   = ports[w].victim_tag;
    assign vic_valid[w] = ports[w].victim_valid;
    assign vic_dirty[w] = ports[w].victim_dirty;
    assign ports[w].wen = wen[w];
  end

  // lowest hitting way wins
  always_comb begin
    hit_any  = 1'b0;
    hit_way  = '0;
    hit_data = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_any  = 1'b1;
        hit_way  = 2'(w);
        hit_data = way_data[w];
      end
    end
  end

  // victim from the tree of the requested set
  always_comb begin
    if (!tree_a[req.index]) begin
      victim_way = tree_b[req.index] ? 2'd1 : 2'd0;
    end else begin
      victim_way = tree_c[req.index] ? 2'd3 : 2'd2;
    end
  end

  assign write_req = req.fire && (req.op == op_write);
  assign alloc     = write_req && !hit_any;

  // hit overwrites in place, miss takes the victim
  always_comb begin
    wen = '0;
    if (write_req) begin
      if (hit_any) begin
        wen[hit_way] = 1'b1;
      end else begin
        wen[victim_way] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tree_a <= '0;
      tree_b <= '0;
      tree_c <= '0;
    end else if (alloc) begin
      tree_a[req.index] <= ~tree_a[req.index];
      if (!tree_a[req.index]) begin
        tree_b[req.index] <= ~tree_b[req.index];
      end else begin
        tree_c[req.index] <= ~tree_c[req.index];
      end
    end
  end

  // write-back of the replaced line one cycle after the access
  always_ff @(posedge clock) begin
    if (reset) begin
      evict_valid <= 1'b0;
    end else begin
      evict_valid <= alloc && vic_valid[victim_way] && vic_dirty[victim_way];
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      evict_addr <= {vic_tag[victim_way], req.index, 2'b00};
      evict_data <= way_data[victim_way];
    end
  end

endmodule
